// ==== issuePkg.sv ====
// issue front end shared definitions
// instruction word, register index, opcode classes and the stage record
// used by the queue, decoder, hazard detector and stage tracker
package issuePkg;

    // one 16-bit instruction, opcode in [15:11]
    typedef logic [15:0] instWord;

    // architectural register number, eight registers
    typedef logic [2:0] regIndex;

    // bubble inserted on a stall or an empty queue
    localparam instWord nopInst = {5'b00001, 11'b0};

    // JAL and JALR write their return address here
    localparam regIndex linkReg = 3'd7;

    // opcode groups, each one sharing operand usage and write-back shape
    typedef enum logic [3:0] {
        // 10000, reads A and B, no write
        store,
        // 10011, reads A and B, writes back the base in [10:8]
        storeUpdate,
        // 11011
        arith,
        // 11010
        bitOp,
        // 111xx, compare and set
        setCond,
        // 11000, writes [10:8] and reads nothing
        loadImmByte,
        // 00000
        halt,
        // 00001
        nop,
        // 0001x, exception entry and return, never stalls on control
        special,
        // 011xx, conditional branch on A
        branch,
        // 001x1, JR and JALR
        jumpReg,
        // 001x0, J and JAL
        jumpDisp,
        // everything else, reads A and writes [7:5]
        immediate
    } instClass;

    // shadow of one in-flight instruction, all the detector needs to know
    typedef struct packed {
        logic    wrEn;
        regIndex dest;
        // set for branches and jumps until the target is resolved
        logic    ctrl;
    } stageRec;

endpackage

// ==== stageIf.sv ====
// in-flight stage records
// carries the D, X, M and W shadow records from the stage tracker
// to the hazard detector
interface stageIf;
    import issuePkg::*;

    // instruction issued last cycle
    stageRec recD;
    // one cycle further on
    stageRec recX;
    stageRec recM;
    // last stage, only control records still matter here
    stageRec recW;

    // tracker side, owns the shadow pipeline
    modport source (
        output recD,
        output recX,
        output recM,
        output recW
    );

    // detector side, compares the head against these
    modport sink (
        input recD,
        input recX,
        input recM,
        input recW
    );

endinterface

// ==== instQueue.sv ====
// instruction queue
// circular buffer between fetch and the hazard detector, head visible
// combinationally, one credit handed back to fetch per popped entry
module instQueue #(
    parameter int QueueDepth = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             instValid,
    input  issuePkg::instWord inst,
    input  logic             pop,
    output logic             headValid,
    output issuePkg::instWord headInst,
    output logic             creditReturn
);
    import issuePkg::*;

    localparam int PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
    localparam int CntW = $clog2(QueueDepth + 1);

    instWord mem [QueueDepth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;

    // wrap at the last entry, depth need not be a power of two
    function automatic logic [PtrW-1:0] advance(input logic [PtrW-1:0] p);
        if (p == PtrW'(QueueDepth - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign headValid = (count != '0);
    assign headInst  = mem[rdPtr];

    // payload storage
    always_ff @(posedge clk) begin
        if (instValid) begin
            mem[wrPtr] <= inst;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            count        <= '0;
            creditReturn <= 1'b0;
        end else begin
            if (instValid) begin
                wrPtr <= advance(wrPtr);
            end
            if (pop) begin
                rdPtr <= advance(rdPtr);
            end
            case ({instValid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // credit goes back the cycle after the entry leaves
            creditReturn <= pop;
        end
    end

    // fetch must respect its credits
    pushNotFull: assert property (@(posedge clk) disable iff (reset)
        instValid |-> (count < CntW'(QueueDepth)));

    // the detector only pops a present head
    popNotEmpty: assert property (@(posedge clk) disable iff (reset)
        pop |-> headValid);

endmodule

// ==== instDecode.sv ====
// instruction decoder
// classifies the opcode and works out which source fields are read,
// which register is written and whether the instruction redirects control
module instDecode (
    input  issuePkg::instWord  inst,
    output issuePkg::instClass cls,
    output logic               usesA,
    output logic               usesB,
    output issuePkg::regIndex  srcA,
    output issuePkg::regIndex  srcB,
    output issuePkg::stageRec  rec
);
    import issuePkg::*;

    logic [4:0] op;

    assign op = inst[15:11];

    // source fields sit at fixed positions, only their use varies
    assign srcA = inst[10:8];
    assign srcB = inst[7:5];

    always_comb begin
        unique casez (op)
            5'b10000: cls = store;
            5'b10011: cls = storeUpdate;
            5'b11011: cls = arith;
            5'b11010: cls = bitOp;
            5'b111??: cls = setCond;
            5'b11000: cls = loadImmByte;
            5'b00000: cls = halt;
            5'b00001: cls = nop;
            5'b0001?: cls = special;
            5'b011??: cls = branch;
            5'b001?1: cls = jumpReg;
            5'b001?0: cls = jumpDisp;
            default:  cls = immediate;
        endcase
    end

    always_comb begin
        usesA = 1'b0;
        usesB = 1'b0;
        rec   = '0;
        case (cls)
            store: begin
                usesA = 1'b1;
                usesB = 1'b1;
            end
            storeUpdate: begin
                usesA    = 1'b1;
                usesB    = 1'b1;
                // updated base goes back to rs
                rec.wrEn = 1'b1;
                rec.dest = inst[10:8];
            end
            arith, bitOp, setCond: begin
                usesA    = 1'b1;
                usesB    = 1'b1;
                rec.wrEn = 1'b1;
                rec.dest = inst[4:2];
            end
            loadImmByte: begin
                rec.wrEn = 1'b1;
                rec.dest = inst[10:8];
            end
            branch: begin
                usesA    = 1'b1;
                rec.ctrl = 1'b1;
            end
            jumpReg, jumpDisp: begin
                usesA    = (cls == jumpReg);
                rec.ctrl = 1'b1;
                // opcode bit 1 picks the linking form, JAL or JALR
                rec.wrEn = op[1];
                rec.dest = op[1] ? linkReg : '0;
            end
            immediate: begin
                usesA    = 1'b1;
                rec.wrEn = 1'b1;
                rec.dest = inst[7:5];
            end
            // halt, nop and special read and write nothing
            default: begin
                rec = '0;
            end
        endcase
    end

endmodule

// ==== hazardDetect.sv ====
// hazard detector
// checks the queue head against the in-flight records, stalls on RAW and
// control hazards and selects EX-to-EX forwarding for a writer in D
module hazardDetect (
    input  logic               headValid,
    input  issuePkg::instWord  headInst,
    input  issuePkg::instClass cls,
    input  logic               usesA,
    input  logic               usesB,
    input  issuePkg::regIndex  srcA,
    input  issuePkg::regIndex  srcB,
    stageIf.sink               stages,
    output logic               pop,
    output logic               stall,
    output logic               fwdA,
    output logic               fwdB,
    output logic               issueValid,
    output issuePkg::instWord  issueInst
);
    import issuePkg::*;

    // per-stage source matches, already qualified by use and write enable
    logic matchDA;
    logic matchDB;
    logic matchXA;
    logic matchXB;
    logic matchMA;
    logic matchMB;
    logic dataHaz;
    logic ctrlHaz;
    logic noFwd;

    assign matchDA = usesA && stages.recD.wrEn && (stages.recD.dest == srcA);
    assign matchDB = usesB && stages.recD.wrEn && (stages.recD.dest == srcB);
    assign matchXA = usesA && stages.recX.wrEn && (stages.recX.dest == srcA);
    assign matchXB = usesB && stages.recX.wrEn && (stages.recX.dest == srcB);
    assign matchMA = usesA && stages.recM.wrEn && (stages.recM.dest == srcA);
    assign matchMB = usesB && stages.recM.wrEn && (stages.recM.dest == srcB);

    // immediate-class ops have no forward path into their A operand
    assign noFwd = (cls == immediate);

    // X and M results are not forwardable, W writes back before the read
    always_comb begin
        dataHaz = matchXA || matchXB || matchMA || matchMB;
        if (noFwd) begin
            dataHaz = dataHaz || matchDA || matchDB;
        end
    end

    // any unresolved branch or jump holds everything behind it
    always_comb begin
        ctrlHaz = stages.recD.ctrl || stages.recX.ctrl ||
                  stages.recM.ctrl || stages.recW.ctrl;
        if (cls == special) begin
            ctrlHaz = 1'b0;
        end
    end

    // an empty queue is a bubble, not a stall
    assign stall = headValid && (dataHaz || ctrlHaz);

    assign pop        = headValid && !stall;
    assign issueValid = pop;
    assign issueInst  = pop ? headInst : nopInst;

    // a D writer feeds the consumer straight out of EX
    assign fwdA = pop && !noFwd && matchDA;
    assign fwdB = pop && !noFwd && matchDB;

endmodule

// ==== stageTrack.sv ====
// stage tracker
// shadow pipeline of D, X, M and W records that advances every clock,
// also holds the registered issue outputs of the D stage
module stageTrack (
    input  logic              clk,
    input  logic              reset,
    input  logic              issueValid,
    input  issuePkg::instWord issueInst,
    input  issuePkg::stageRec issueRec,
    input  logic              fwdA,
    input  logic              fwdB,
    stageIf.source            stages,
    output issuePkg::instWord issuedInst,
    output logic              fwdASel,
    output logic              fwdBSel
);
    import issuePkg::*;

    // downstream never stalls, so the records shift unconditionally
    always_ff @(posedge clk) begin
        if (reset) begin
            stages.recD <= '0;
            stages.recX <= '0;
            stages.recM <= '0;
            stages.recW <= '0;
            issuedInst  <= nopInst;
            fwdASel     <= 1'b0;
            fwdBSel     <= 1'b0;
        end else begin
            stages.recW <= stages.recM;
            stages.recM <= stages.recX;
            stages.recX <= stages.recD;
            // bubbles enter D as an empty record
            stages.recD <= issueValid ? issueRec : '0;
            issuedInst  <= issueInst;
            fwdASel     <= fwdA;
            fwdBSel     <= fwdB;
        end
    end

    // a NOP-opcode word in D never writes or redirects, whether it came
    // from the detector as a bubble or from the queue
    bubbleNoWrite: assert property (@(posedge clk) disable iff (reset)
        (issuedInst[15:11] == nopInst[15:11]) |-> (!stages.recD.wrEn && !stages.recD.ctrl));

    // a forward select only comes with an issued instruction, never with a stall
    fwdOnlyOnIssue: assert property (@(posedge clk) disable iff (reset)
        (fwdA || fwdB) |-> issueValid);

endmodule

// ==== issueFront.sv ====
// issue-control front end
// credit-fed instruction queue, decoder, hazard detector and stage tracker
// of a five-stage in-order pipeline
module issueFront #(
    parameter int QueueDepth = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              instValid,
    input  issuePkg::instWord inst,
    output logic              creditReturn,
    output issuePkg::instWord issuedInst,
    output logic              fwdASel,
    output logic              fwdBSel,
    output logic              stallOut
);
    import issuePkg::*;

    // queue head
    logic     headValid;
    instWord  headInst;
    logic     pop;

    // decoded head
    instClass cls;
    logic     usesA;
    logic     usesB;
    regIndex  srcA;
    regIndex  srcB;
    stageRec  headRec;

    // issue decision
    logic     issueValid;
    instWord  issueInst;
    logic     fwdA;
    logic     fwdB;

    stageIf stages ();

    instQueue #(
        .QueueDepth (QueueDepth)
    ) queue (
        .clk          (clk),
        .reset        (reset),
        .instValid    (instValid),
        .inst         (inst),
        .pop          (pop),
        .headValid    (headValid),
        .headInst     (headInst),
        .creditReturn (creditReturn)
    );

    instDecode decode (
        .inst  (headInst),
        .cls   (cls),
        .usesA (usesA),
        .usesB (usesB),
        .srcA  (srcA),
        .srcB  (srcB),
        .rec   (headRec)
    );

    hazardDetect detect (
        .headValid  (headValid),
        .headInst   (headInst),
        .cls        (cls),
        .usesA      (usesA),
        .usesB      (usesB),
        .srcA       (srcA),
        .srcB       (srcB),
        .stages     (stages.sink),
        .pop        (pop),
        .stall      (stallOut),
        .fwdA       (fwdA),
        .fwdB       (fwdB),
        .issueValid (issueValid),
        .issueInst  (issueInst)
    );

    stageTrack track (
        .clk        (clk),
        .reset      (reset),
        .issueValid (issueValid),
        .issueInst  (issueInst),
        .issueRec   (headRec),
        .fwdA       (fwdA),
        .fwdB       (fwdB),
        .stages     (stages.source),
        .issuedInst (issuedInst),
        .fwdASel    (fwdASel),
        .fwdBSel    (fwdBSel)
    );

endmodule

// ==== issueFront_tb.sv ====
// testbench for the issue-control front end
// table-driven fetch with credit tracking, checked each cycle against
// a reference model of the queue, the stage records and the hazard rules
module issueFront_tb;
    import issuePkg::*;

    localparam int QueueDepth = 4;

    logic    clk;
    logic    reset;
    logic    instValid;
    instWord inst;
    logic    creditReturn;
    instWord issuedInst;
    logic    fwdASel;
    logic    fwdBSel;
    logic    stallOut;

    // stimulus table, one row per instruction
    int      tTest [$];
    instWord tWord [$];
    int      tGap [$];
    logic    tableReady;
    string   testName [1:6];

    // reference model, index 0 is D and 3 is W
    instWord mq [$];
    logic    rWr [4];
    regIndex rDst [4];
    logic    rCtl [4];
    instWord expIssued;
    logic    expFwdA;
    logic    expFwdB;
    logic    expCredit;

    int credits;
    int errors;
    int testErrStart;
    int testsPassed;
    int testsFailed;
    int stallSeen;
    int fwdASeen;
    int fwdBSeen;
    int starved;
    int creditPulses;
    int accepted;
    instWord sentList [$];
    instWord issuedList [$];
    logic [31:0] rngState;

    issueFront #(
        .QueueDepth (QueueDepth)
    ) uut (
        .clk          (clk),
        .reset        (reset),
        .instValid    (instValid),
        .inst         (inst),
        .creditReturn (creditReturn),
        .issuedInst   (issuedInst),
        .fwdASel      (fwdASel),
        .fwdBSel      (fwdBSel),
        .stallOut     (stallOut)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] nextRandom(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic instWord arithWord(input int rd, input int ra, input int rb);
        return {5'b11011, 3'(ra), 3'(rb), 3'(rd), 2'b00};
    endfunction

    // opcode 01000 falls in the immediate group
    function automatic instWord immWord(input int rd, input int ra);
        return {5'b01000, 3'(ra), 3'(rd), 5'b00011};
    endfunction

    function automatic instWord ctrlWord(input logic [4:0] op, input int ra);
        return {op, 3'(ra), 8'h00};
    endfunction

    // one opcode per class, free bits of the class filled from r
    function automatic logic [4:0] randomOpcode(input int k, input logic [4:0] r);
        case (k)
            0:       return 5'b10000;
            1:       return 5'b10011;
            2:       return 5'b11011;
            3:       return 5'b11010;
            4:       return {3'b111, r[1:0]};
            5:       return 5'b11000;
            6:       return 5'b00000;
            7:       return 5'b00001;
            8:       return {4'b0001, r[0]};
            9:       return {3'b011, r[1:0]};
            10:      return {3'b001, r[1], 1'b1};
            11:      return {3'b001, r[1], 1'b0};
            default: return {3'b010, r[1:0]};
        endcase
    endfunction

    // operand use and write-back per opcode group
    function automatic void refDecode(input instWord w, output logic ua, output logic ub,
                                      output logic wr, output regIndex dst, output logic ctl,
                                      output logic imm, output logic spc);
        logic [4:0] op;
        op  = w[15:11];
        ua  = 1'b0;
        ub  = 1'b0;
        wr  = 1'b0;
        dst = '0;
        ctl = 1'b0;
        imm = 1'b0;
        spc = 1'b0;
        if (op == 5'b10000) begin
            ua = 1'b1;
            ub = 1'b1;
        end else if (op == 5'b10011 || op == 5'b11000) begin
            // updated base or loaded byte goes to [10:8]
            ua  = (op == 5'b10011);
            ub  = (op == 5'b10011);
            wr  = 1'b1;
            dst = w[10:8];
        end else if (op == 5'b11011 || op == 5'b11010 || op[4:2] == 3'b111) begin
            ua  = 1'b1;
            ub  = 1'b1;
            wr  = 1'b1;
            dst = w[4:2];
        end else if (op[4:1] == 4'b0001) begin
            spc = 1'b1;
        end else if (op[4:2] == 3'b011 || op[4:2] == 3'b001) begin
            // branches, JR and JALR read A, linking jumps write r7
            ua  = (op[4:2] == 3'b011) || op[0];
            ctl = 1'b1;
            wr  = (op[4:2] == 3'b001) && op[1];
            dst = wr ? regIndex'(7) : regIndex'(0);
        end else if (op[4:1] != 4'b0000) begin
            ua  = 1'b1;
            wr  = 1'b1;
            dst = w[7:5];
            imm = 1'b1;
        end
    endfunction

    task automatic addEntry(input int id, input instWord w, input int gap);
        tTest.push_back(id);
        tWord.push_back(w);
        tGap.push_back(gap);
    endtask

    task automatic compareField(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // check this negedge, drive the next edge, advance the model past it
    task automatic runCycle(input logic want, input instWord w, output logic sent);
        logic    ua;
        logic    ub;
        logic    wr;
        regIndex dst;
        logic    ctl;
        logic    imm;
        logic    spc;
        logic    hv;
        instWord head;
        logic    dataHaz;
        logic    stall;
        logic    pop;
        logic    fa;
        logic    fb;
        int      s;
        hv   = (mq.size() != 0);
        head = hv ? mq[0] : '0;
        refDecode(head, ua, ub, wr, dst, ctl, imm, spc);
        // X and M writers stall, a D writer only for immediate consumers
        dataHaz = 1'b0;
        for (s = imm ? 0 : 1; s <= 2; s++) begin
            if (rWr[s] && ((ua && rDst[s] == head[10:8]) || (ub && rDst[s] == head[7:5]))) begin
                dataHaz = 1'b1;
            end
        end
        stall = hv && (dataHaz || (!spc && (rCtl[0] || rCtl[1] || rCtl[2] || rCtl[3])));
        pop   = hv && !stall;
        fa    = pop && !imm && ua && rWr[0] && (rDst[0] == head[10:8]);
        fb    = pop && !imm && ub && rWr[0] && (rDst[0] == head[7:5]);

        compareField("issuedInst", issuedInst, expIssued);
        compareField("fwdASel", fwdASel, expFwdA);
        compareField("fwdBSel", fwdBSel, expFwdB);
        compareField("stallOut", stallOut, stall);
        compareField("creditReturn", creditReturn, expCredit);
        stallSeen += (stallOut === 1'b1);
        fwdASeen  += (fwdASel === 1'b1);
        fwdBSeen  += (fwdBSel === 1'b1);
        if (issuedInst !== nopInst) begin
            issuedList.push_back(issuedInst);
        end

        // fetch side, one credit back per pulse
        if (creditReturn === 1'b1) begin
            credits++;
            creditPulses++;
        end
        if (credits > QueueDepth) begin
            $display("more credits returned than the queue has entries at %0t", $time);
            errors++;
        end
        starved += (want && credits == 0);
        sent = want && (credits > 0);
        if (sent) begin
            if (mq.size() >= QueueDepth) begin
                $display("fetch pushed into a full queue at %0t", $time);
                errors++;
            end
            credits--;
            accepted++;
            sentList.push_back(w);
        end
        instValid = sent;
        inst      = sent ? w : '0;

        for (s = 3; s > 0; s--) begin
            rWr[s]  = rWr[s-1];
            rDst[s] = rDst[s-1];
            rCtl[s] = rCtl[s-1];
        end
        rWr[0]    = pop && wr;
        rDst[0]   = pop ? dst : '0;
        rCtl[0]   = pop && ctl;
        expIssued = pop ? head : nopInst;
        expFwdA   = fa;
        expFwdB   = fb;
        expCredit = pop;
        if (pop) begin
            mq.delete(0);
        end
        if (sent) begin
            mq.push_back(w);
        end
        @(negedge clk);
    endtask

    task automatic sendEntry(input instWord w);
        logic sent;
        sent = 1'b0;
        while (!sent) begin
            runCycle(1'b1, w, sent);
        end
    endtask

    // drain the pipeline, then judge the test as a whole
    task automatic finishTest(input int id);
        logic dummy;
        int   n;
        while (mq.size() != 0 || rWr[0] || rWr[1] || rWr[2] || rWr[3] || rCtl[0] || rCtl[1] ||
               rCtl[2] || rCtl[3] || expIssued !== nopInst || credits != QueueDepth) begin
            runCycle(1'b0, '0, dummy);
        end
        if ((id == 2 && (fwdASeen == 0 || fwdBSeen == 0)) || (id == 3 && stallSeen == 0) ||
            (id == 4 && stallSeen == 0) || (id == 5 && starved == 0)) begin
            $display("test %0d never reached the situation it was built for", id);
            errors++;
        end
        if (creditPulses != accepted) begin
            $display("%0d credit pulses for %0d accepted instructions", creditPulses, accepted);
            errors++;
        end
        if (sentList.size() != issuedList.size()) begin
            $display("%0d instructions sent but %0d issued", sentList.size(), issuedList.size());
            errors++;
        end else begin
            for (n = 0; n < sentList.size(); n++) begin
                compareField("issuedInst order", issuedList[n], sentList[n]);
            end
        end
        n = errors - testErrStart;
        $display("test %0d %s: %s, %0d errors", id, testName[id], (n == 0) ? "ok" : "bad", n);
        testsPassed += (n == 0);
        testsFailed += (n != 0);
        {stallSeen, fwdASeen, fwdBSeen, starved, creditPulses, accepted} = '0;
        sentList.delete();
        issuedList.delete();
        testErrStart = errors;
    endtask

    task automatic buildTable();
        logic [31:0] r;
        instWord     w;
        int          n;
        testName[1] = "reset and flow";
        testName[2] = "forwarding";
        testName[3] = "data stalls";
        testName[4] = "control flow";
        testName[5] = "back-pressure";
        testName[6] = "random mix";
        addEntry(1, arithWord(1, 2, 3), 0);
        addEntry(1, arithWord(4, 5, 6), 0);
        addEntry(1, {5'b10000, 3'd7, 3'd6, 5'd0}, 2);
        // producer then consumer on A, drain, producer then consumer on B
        addEntry(2, arithWord(1, 2, 3), 0);
        addEntry(2, arithWord(4, 1, 5), 0);
        addEntry(2, arithWord(1, 2, 3), 4);
        addEntry(2, arithWord(5, 6, 1), 0);
        // producer in X, producer in M, immediate on a D writer
        addEntry(3, arithWord(1, 2, 3), 0);
        addEntry(3, arithWord(4, 5, 6), 0);
        addEntry(3, arithWord(6, 1, 2), 0);
        addEntry(3, arithWord(2, 3, 4), 4);
        addEntry(3, arithWord(5, 6, 7), 0);
        addEntry(3, arithWord(0, 6, 7), 0);
        addEntry(3, arithWord(7, 2, 3), 0);
        addEntry(3, arithWord(3, 2, 2), 4);
        addEntry(3, immWord(5, 3), 0);
        // branch, JALR, JAL with a special behind it, JR
        addEntry(4, ctrlWord(5'b01100, 1), 0);
        addEntry(4, arithWord(2, 3, 4), 0);
        addEntry(4, ctrlWord(5'b00111, 3), 3);
        addEntry(4, arithWord(1, 7, 2), 0);
        addEntry(4, ctrlWord(5'b00110, 0), 3);
        addEntry(4, ctrlWord(5'b00010, 0), 0);
        addEntry(4, arithWord(3, 1, 1), 0);
        addEntry(4, ctrlWord(5'b00101, 2), 3);
        // long control stall while fetch keeps pushing
        addEntry(5, ctrlWord(5'b01101, 4), 0);
        for (n = 0; n < 7; n++) begin
            addEntry(5, arithWord(n, (n + 1) % 8, (n + 2) % 8), 0);
        end
        for (n = 0; n < 200; n++) begin
            rngState = nextRandom(rngState);
            r        = rngState;
            rngState = nextRandom(rngState);
            w        = {randomOpcode(int'(r % 13), r[20:16]), rngState[10:0]};
            // a bare NOP word would vanish from the issued sequence
            if (w == nopInst) begin
                w[0] = 1'b1;
            end
            addEntry(6, w, (r[31:29] == 3'b000) ? int'(r[28:27]) : 0);
        end
    endtask

    // run limit scales with the table
    initial begin
        wait (tableReady);
        repeat (tWord.size() * 12 + 10) @(posedge clk);
        $display("watchdog expired before the table finished");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int   i;
        int   curTest;
        logic idle;
        clk        = 1'b0;
        reset      = 1'b1;
        instValid  = 1'b0;
        inst       = '0;
        tableReady = 1'b0;
        rngState   = 32'h035e_8d84;
        credits    = QueueDepth;
        expIssued  = nopInst;
        {expFwdA, expFwdB, expCredit} = '0;
        {errors, testErrStart, testsPassed, testsFailed} = '0;
        {stallSeen, fwdASeen, fwdBSeen, starved, creditPulses, accepted} = '0;
        for (i = 0; i < 4; i++) begin
            rWr[i]  = 1'b0;
            rDst[i] = '0;
            rCtl[i] = 1'b0;
        end
        buildTable();
        tableReady = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset   = 1'b0;
        curTest = tTest[0];
        for (i = 0; i < tWord.size(); i++) begin
            if (tTest[i] != curTest) begin
                finishTest(curTest);
                curTest = tTest[i];
            end
            repeat (tGap[i]) runCycle(1'b0, '0, idle);
            sendEntry(tWord[i]);
        end
        finishTest(curTest);
        $display("tests passed %0d, failed %0d, errors %0d", testsPassed, testsFailed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== issueFront.f ====
issuePkg.sv
stageIf.sv
instQueue.sv
instDecode.sv
hazardDetect.sv
stageTrack.sv
issueFront.sv
issueFront_tb.sv
